// File: hw/fft_pkg.sv
package fft_pkg;

  ////////////////////
  // word widths
  ////////////////////

  // Q1.9 input component
  localparam int in_w   = 10;
  // stage I grows by one bit, Q2.9
  localparam int s1_w   = in_w + 1;
  // stage II grows by one more, Q3.9
  localparam int s2_w   = s1_w + 1;
  // coefficient width, Q1.10
  localparam int coef_w = 11;
  // rotator product, Q5.19, exact
  localparam int prod_w = s2_w + coef_w + 1;
  // output component, Q3.12
  localparam int out_w  = 15;

  ////////////////////
  // csd constants
  ////////////////////

  // cos(pi/8) in Q1.10, 1024 - 64 - 16 + 2
  localparam logic signed [coef_w-1:0] coef_c1 = 11'sd946;
  // sin(pi/8) in Q1.10, 512 - 128 + 8
  localparam logic signed [coef_w-1:0] coef_s1 = 11'sd392;

  // Q3.12 saturation limits
  localparam logic signed [out_w-1:0] sat_max = 15'sd16383;
  localparam logic signed [out_w-1:0] sat_min = -15'sd16384;

  ////////////////////
  // complex samples
  ////////////////////

  typedef struct packed {
    logic signed [in_w-1:0] re;
    logic signed [in_w-1:0] im;
  } cplx_in_t;

  typedef struct packed {
    logic signed [s1_w-1:0] re;
    logic signed [s1_w-1:0] im;
  } cplx_s1_t;

  typedef struct packed {
    logic signed [s2_w-1:0] re;
    logic signed [s2_w-1:0] im;
  } cplx_s2_t;

  typedef struct packed {
    logic signed [prod_w-1:0] re;
    logic signed [prod_w-1:0] im;
  } cplx_prod_t;

  typedef struct packed {
    logic signed [out_w-1:0] re;
    logic signed [out_w-1:0] im;
  } cplx_out_t;

  // four input lanes, x0 x2 x1 x3
  typedef struct packed {
    cplx_in_t in0_up;
    cplx_in_t in0_down;
    cplx_in_t in1_up;
    cplx_in_t in1_down;
  } quad_in_t;

  // four output lanes, X0 X2 X1 X3
  typedef struct packed {
    cplx_out_t out0_up;
    cplx_out_t out0_down;
    cplx_out_t out1_up;
    cplx_out_t out1_down;
  } quad_out_t;

endpackage

// File: hw/fft_sequencer.sv
`timescale 1ns/1ps

module fft_sequencer #(
  parameter int twd_period = 32
) (
  input  logic clk,
  input  logic rst,
  output logic twd,
  output logic fill
);

  // counter wraps once per twiddle window
  localparam int cnt_w = $clog2(twd_period);

  logic [cnt_w-1:0] cyc_cnt;
  logic [1:0]       fill_cnt;

  ////////////////////
  // window counter
  ////////////////////

  // holds c mod twd_period for the set sampled at edge c
  always_ff @(posedge clk) begin
    if (rst) begin
      cyc_cnt <= '0;
    end else begin
      cyc_cnt <= cyc_cnt + 1'b1;
    end
  end

  // second half of the window, msb of a power-of-two count
  assign twd = cyc_cnt[cnt_w-1];

  ////////////////////
  // pipeline fill
  ////////////////////

  // stops at 3, three edges after reset release
  always_ff @(posedge clk) begin
    if (rst) begin
      fill_cnt <= 2'd0;
    end else if (fill_cnt != 2'd3) begin
      fill_cnt <= fill_cnt + 2'd1;
    end
  end

  // high from edge 2 on, output enable follows one edge later
  assign fill = (fill_cnt == 2'd3);

endmodule

// File: hw/stage1_butterfly.sv
`timescale 1ns/1ps

module stage1_butterfly
  import fft_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     twd,
  input  cplx_in_t a,
  input  cplx_in_t b,
  output cplx_s1_t sum,
  output cplx_s1_t diff
);

  cplx_s1_t sum_d;
  cplx_s1_t sub_d;
  cplx_s1_t diff_d;

  ////////////////////
  // butterfly
  ////////////////////

  always_comb begin
    // sign extend first, one bit of growth covers the full range
    sum_d.re = s1_w'(a.re) + s1_w'(b.re);
    sum_d.im = s1_w'(a.im) + s1_w'(b.im);
    sub_d.re = s1_w'(a.re) - s1_w'(b.re);
    sub_d.im = s1_w'(a.im) - s1_w'(b.im);
  end

  // -j rotation in the second half of the window
  always_comb begin
    if (twd) begin
      // (re + j im)(-j) = im - j re
      diff_d.re = sub_d.im;
      diff_d.im = -sub_d.re;
    end else begin
      diff_d = sub_d;
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sum  <= '0;
      diff <= '0;
    end else begin
      sum  <= sum_d;
      diff <= diff_d;
    end
  end

endmodule

// File: hw/stage2_butterfly.sv
`timescale 1ns/1ps

module stage2_butterfly
  import fft_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  cplx_s1_t a,
  input  cplx_s1_t b,
  output cplx_s2_t sum,
  output cplx_s2_t diff
);

  cplx_s2_t sum_d;
  cplx_s2_t diff_d;

  ////////////////////
  // butterfly
  ////////////////////

  // full precision, Q2.9 in and Q3.9 out
  always_comb begin
    sum_d.re  = s2_w'(a.re) + s2_w'(b.re);
    sum_d.im  = s2_w'(a.im) + s2_w'(b.im);
    diff_d.re = s2_w'(a.re) - s2_w'(b.re);
    diff_d.im = s2_w'(a.im) - s2_w'(b.im);
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sum  <= '0;
      diff <= '0;
    end else begin
      sum  <= sum_d;
      diff <= diff_d;
    end
  end

endmodule

// File: hw/csd_rotator.sv
`timescale 1ns/1ps

module csd_rotator
  import fft_pkg::*;
#(
  parameter int rot_sel = 0
) (
  input  logic       clk,
  input  logic       rst,
  input  cplx_s2_t   x,
  output cplx_prod_t y
);

  // one constant product, one bit short of the final sum
  localparam int term_w = prod_w - 1;

  // pi/8 uses (c1, s1), 3pi/8 swaps them
  localparam int coef_c = (rot_sel == 0) ? int'(coef_c1) : int'(coef_s1);
  localparam int coef_s = (rot_sel == 0) ? int'(coef_s1) : int'(coef_c1);

  logic signed [term_w-1:0] xr_c;
  logic signed [term_w-1:0] xr_s;
  logic signed [term_w-1:0] xi_c;
  logic signed [term_w-1:0] xi_s;
  cplx_prod_t               y_d;

  ////////////////////
  // csd multiply
  ////////////////////

  // v * k as signed shift and add terms
  // digits are the non-adjacent form of k, so
  // 946 -> +1024 -64 -16 +2
  // 392 -> +512 -128 +8
  // k is constant per instance, only the adders remain
  function automatic logic signed [term_w-1:0] csd_mul(
    input logic signed [s2_w-1:0] v,
    input int                     k
  );
    int                       rem;
    int                       digit;
    logic signed [term_w-1:0] ext;
    logic signed [term_w-1:0] acc;
    rem = k;
    ext = term_w'(v);
    acc = '0;
    for (int i = 0; i <= coef_w; i++) begin
      if (rem % 2 != 0) begin
        // +1 when rem ends in 01, -1 when it ends in 11
        digit = 2 - (rem % 4);
        rem   = rem - digit;
        if (digit > 0) begin
          acc = acc + (ext <<< i);
        end else begin
          acc = acc - (ext <<< i);
        end
      end
      rem = rem / 2;
    end
    return acc;
  endfunction

  always_comb begin
    xr_c = csd_mul(x.re, coef_c);
    xr_s = csd_mul(x.re, coef_s);
    xi_c = csd_mul(x.im, coef_c);
    xi_s = csd_mul(x.im, coef_s);
    // x * (c - j s)
    y_d.re = prod_w'(xr_c) + prod_w'(xi_s);
    y_d.im = prod_w'(xi_c) - prod_w'(xr_s);
  end

  ////////////////////
  // output register
  ////////////////////

  // exact Q5.19, rounding left to the output stage
  always_ff @(posedge clk) begin
    if (rst) begin
      y <= '0;
    end else begin
      y <= y_d;
    end
  end

endmodule

// File: hw/fft_out_stage.sv
`timescale 1ns/1ps

module fft_out_stage
  import fft_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       fill,
  input  cplx_s2_t   x0,
  input  cplx_s2_t   x2,
  input  cplx_prod_t p1,
  input  cplx_prod_t p3,
  output quad_out_t  dout,
  output logic       o_enable
);

  // Q3.9 to Q3.12 on the even path
  localparam int pad_w  = out_w - s2_w;
  // Q5.19 to Q5.12 on the odd path
  localparam int drop_w = 7;
  localparam int trn_w  = prod_w - drop_w;

  cplx_s2_t  x0_q;
  cplx_s2_t  x2_q;
  quad_out_t dout_d;

  ////////////////////
  // odd path helpers
  ////////////////////

  // drop low fraction bits, floor toward minus infinity
  function automatic logic signed [trn_w-1:0] trunc_frac(
    input logic signed [prod_w-1:0] v
  );
    return v[prod_w-1:drop_w];
  endfunction

  // clamp Q5.12 into Q3.12
  function automatic logic signed [out_w-1:0] sat_out(
    input logic signed [trn_w-1:0] v
  );
    if (v > trn_w'(sat_max)) begin
      return sat_max;
    end else if (v < trn_w'(sat_min)) begin
      return sat_min;
    end
    return v[out_w-1:0];
  endfunction

  ////////////////////
  // even path delay
  ////////////////////

  // one stage to line up with the rotators
  always_ff @(posedge clk) begin
    if (rst) begin
      x0_q <= '0;
      x2_q <= '0;
    end else begin
      x0_q <= x0;
      x2_q <= x2;
    end
  end

  always_comb begin
    // even path is exact, just pad the fraction
    dout_d.out0_up.re   = {x0_q.re, {pad_w{1'b0}}};
    dout_d.out0_up.im   = {x0_q.im, {pad_w{1'b0}}};
    dout_d.out0_down.re = {x2_q.re, {pad_w{1'b0}}};
    dout_d.out0_down.im = {x2_q.im, {pad_w{1'b0}}};
    // rotated X1 and X3
    dout_d.out1_up.re   = sat_out(trunc_frac(p1.re));
    dout_d.out1_up.im   = sat_out(trunc_frac(p1.im));
    dout_d.out1_down.re = sat_out(trunc_frac(p3.re));
    dout_d.out1_down.im = sat_out(trunc_frac(p3.im));
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      dout     <= '0;
      o_enable <= 1'b0;
    end else begin
      dout     <= dout_d;
      o_enable <= fill;
    end
  end

endmodule

// File: hw/fft4_front.sv
`timescale 1ns/1ps

module fft4_front
  import fft_pkg::*;
#(
  parameter int twd_period = 32
) (
  input  logic      clk,
  input  logic      rst,
  input  quad_in_t  din,
  output quad_out_t dout,
  output logic      o_enable
);

  logic       twd;
  logic       fill;

  // stage I outputs
  cplx_s1_t   bf1_a_sum;
  cplx_s1_t   bf1_a_diff;
  cplx_s1_t   bf1_b_sum;
  cplx_s1_t   bf1_b_diff;

  // stage II outputs
  cplx_s2_t   x0;
  cplx_s2_t   x2;
  cplx_s2_t   x1;
  cplx_s2_t   x3;

  // rotated odd bins
  cplx_prod_t p1;
  cplx_prod_t p3;

  ////////////////////
  // control
  ////////////////////

  fft_sequencer #(
    .twd_period(twd_period)
  ) u_sequencer (
    .clk (clk),
    .rst (rst),
    .twd (twd),
    .fill(fill)
  );

  ////////////////////
  // stage I
  ////////////////////

  // x0 with x2
  stage1_butterfly u_bf1_a (
    .clk (clk),
    .rst (rst),
    .twd (twd),
    .a   (din.in0_up),
    .b   (din.in0_down),
    .sum (bf1_a_sum),
    .diff(bf1_a_diff)
  );

  // x1 with x3
  stage1_butterfly u_bf1_b (
    .clk (clk),
    .rst (rst),
    .twd (twd),
    .a   (din.in1_up),
    .b   (din.in1_down),
    .sum (bf1_b_sum),
    .diff(bf1_b_diff)
  );

  ////////////////////
  // stage II
  ////////////////////

  // even bins X0 and X2
  stage2_butterfly u_bf2_even (
    .clk (clk),
    .rst (rst),
    .a   (bf1_a_sum),
    .b   (bf1_b_sum),
    .sum (x0),
    .diff(x2)
  );

  // odd bins X1 and X3, still unrotated
  stage2_butterfly u_bf2_odd (
    .clk (clk),
    .rst (rst),
    .a   (bf1_a_diff),
    .b   (bf1_b_diff),
    .sum (x1),
    .diff(x3)
  );

  ////////////////////
  // twiddles
  ////////////////////

  csd_rotator #(
    .rot_sel(0)
  ) u_rot_1 (
    .clk(clk),
    .rst(rst),
    .x  (x1),
    .y  (p1)
  );

  csd_rotator #(
    .rot_sel(1)
  ) u_rot_3 (
    .clk(clk),
    .rst(rst),
    .x  (x3),
    .y  (p3)
  );

  ////////////////////
  // output
  ////////////////////

  fft_out_stage u_out_stage (
    .clk     (clk),
    .rst     (rst),
    .fill    (fill),
    .x0      (x0),
    .x2      (x2),
    .p1      (p1),
    .p3      (p3),
    .dout    (dout),
    .o_enable(o_enable)
  );

endmodule

// File: testbench/fft4_checker.sv
`timescale 1ns/1ps

module fft4_checker
  import fft_pkg::*;
#(
  parameter int twd_period = 32
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [2:0] test_id,
  input  quad_in_t   din,
  input  quad_out_t  dout,
  input  logic       o_enable,
  output int         value_errs,
  output int         enable_errs,
  output int         sets_checked
);

  // three register edges, then read back one edge later
  localparam int read_lag = 4;

  int        cyc = 0;
  int        value_cnt = 0;
  int        enable_cnt = 0;
  int        check_cnt = 0;
  // expected sets in flight, oldest first
  quad_out_t exp_q[$];
  int        due_q[$];
  int        tid_q[$];

  assign value_errs   = value_cnt;
  assign enable_errs  = enable_cnt;
  assign sets_checked = check_cnt;

  function automatic string test_name(input int id);
    case (id)
      1: return "known_sets";
      2: return "random_stream";
      3: return "saturation";
      4: return "mid_reset";
      default: return "idle";
    endcase
  endfunction

  // second half of the window
  function automatic logic twd_at(input int c);
    return (c % twd_period) >= (twd_period / 2);
  endfunction

  // drop 7 fraction bits (floor), then clamp to Q3.12
  function automatic logic signed [out_w-1:0] floor_sat(input int p);
    int q;
    q = p >>> 7;
    if (q > int'(sat_max)) begin
      return sat_max;
    end else if (q < int'(sat_min)) begin
      return sat_min;
    end
    return out_w'(q);
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic quad_out_t fft4_ref(input quad_in_t x, input logic twd);
    int        x0r, x0i, x1r, x1i, x2r, x2i, x3r, x3i;
    int        d0r, d0i, d1r, d1i, tmp;
    int        o1r, o1i, o3r, o3i;
    int        c, s;
    quad_out_t r;
    x0r = x.in0_up.re;
    x0i = x.in0_up.im;
    x2r = x.in0_down.re;
    x2i = x.in0_down.im;
    x1r = x.in1_up.re;
    x1i = x.in1_up.im;
    x3r = x.in1_down.re;
    x3i = x.in1_down.im;
    // even bins, exact dft, scaled by 8 into Q3.12
    r.out0_up.re   = out_w'((x0r + x1r + x2r + x3r) * 8);
    r.out0_up.im   = out_w'((x0i + x1i + x2i + x3i) * 8);
    r.out0_down.re = out_w'((x0r - x1r + x2r - x3r) * 8);
    r.out0_down.im = out_w'((x0i - x1i + x2i - x3i) * 8);
    // odd bins from the two differences
    d0r = x0r - x2r;
    d0i = x0i - x2i;
    d1r = x1r - x3r;
    d1i = x1i - x3i;
    if (twd) begin
      // times -j
      tmp = d0r;
      d0r = d0i;
      d0i = -tmp;
      tmp = d1r;
      d1r = d1i;
      d1i = -tmp;
    end
    o1r = d0r + d1r;
    o1i = d0i + d1i;
    o3r = d0r - d1r;
    o3i = d0i - d1i;
    c = coef_c1;
    s = coef_s1;
    // pi/8 on X1
    r.out1_up.re   = floor_sat(o1r * c + o1i * s);
    r.out1_up.im   = floor_sat(o1i * c - o1r * s);
    // 3pi/8 on X3, cos and sin trade places
    r.out1_down.re = floor_sat(o3r * s + o3i * c);
    r.out1_down.im = floor_sat(o3i * s - o3r * c);
    return r;
  endfunction

  ////////////////////
  // compare helpers
  ////////////////////

  task automatic check_lane(input string tname, input string lane,
                            input cplx_out_t e, input cplx_out_t a);
    if (a !== e) begin
      value_cnt++;
      $display("CHECK FAILED %s %s at %0t: expected (%0d, %0d) actual (%0d, %0d)",
               tname, lane, $time, e.re, e.im, a.re, a.im);
    end
  endtask

  task automatic check_set(input string tname, input quad_out_t e, input quad_out_t a);
    check_lane(tname, "out0_up", e.out0_up, a.out0_up);
    check_lane(tname, "out0_down", e.out0_down, a.out0_down);
    check_lane(tname, "out1_up", e.out1_up, a.out1_up);
    check_lane(tname, "out1_down", e.out1_down, a.out1_down);
  endtask

  ////////////////////
  // watch and compare
  ////////////////////

  // dout and o_enable read here still hold the previous edge's values
  always @(posedge clk) begin : watch
    logic due_now;
    if (rst) begin
      // pipeline and window start over
      exp_q.delete();
      due_q.delete();
      tid_q.delete();
      cyc = 0;
    end else begin
      due_now = (due_q.size() > 0) && (due_q[0] == cyc);
      if (o_enable) begin
        if (due_now) begin
          check_set(test_name(tid_q[0]), exp_q[0], dout);
          check_cnt++;
        end else begin
          enable_cnt++;
          $display("o_enable is high at edge %0d after reset with no output set due (%s)",
                   cyc, test_name(test_id));
        end
      end else begin
        if (due_now) begin
          enable_cnt++;
          $display("o_enable is low at edge %0d after reset while an output set is due (%s)",
                   cyc, test_name(tid_q[0]));
        end
        // cleared registers read as zero
        check_set(test_name(test_id), '0, dout);
      end
      if (due_now) begin
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
        void'(tid_q.pop_front());
      end
      // this edge's input set
      exp_q.push_back(fft4_ref(din, twd_at(cyc)));
      due_q.push_back(cyc + read_lag);
      tid_q.push_back(test_id);
      cyc++;
    end
  end

endmodule

// File: testbench/tb_fft4_front.sv
`timescale 1ns/1ps

module tb_fft4_front
  import fft_pkg::*;
();

  localparam int clk_period = 40;
  localparam int twd_period = 32;

  // vectors per phase at one per clock
  localparam int n_known     = twd_period;
  localparam int n_random    = 4 * twd_period;
  localparam int n_sat       = 6;
  localparam int n_pre_rst   = 20;
  localparam int n_rst_mid   = 3;
  localparam int n_post_rst  = 40;
  localparam int n_flush     = 4;
  localparam int num_vectors = n_known + n_random + n_sat + n_pre_rst + n_rst_mid +
                               n_post_rst + n_flush;

  logic       clk;
  logic       rst;
  logic [2:0] test_id;
  quad_in_t   din;
  quad_out_t  dout;
  logic       o_enable;
  int         value_errs;
  int         enable_errs;
  int         sets_checked;
  int         seed = 32'h0eafd119;
  // sets sampled since the last reset release
  int         since_rst = 0;

  ////////////////////
  // clock, dut, checker
  ////////////////////

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  fft4_front #(
    .twd_period(twd_period)
  ) u_fft4_front (
    .clk     (clk),
    .rst     (rst),
    .din     (din),
    .dout    (dout),
    .o_enable(o_enable)
  );

  fft4_checker #(
    .twd_period(twd_period)
  ) u_checker (
    .clk         (clk),
    .rst         (rst),
    .test_id     (test_id),
    .din         (din),
    .dout        (dout),
    .o_enable    (o_enable),
    .value_errs  (value_errs),
    .enable_errs (enable_errs),
    .sets_checked(sets_checked)
  );

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic cplx_in_t cplx(input int re, input int im);
    cplx_in_t r;
    r.re = in_w'(re);
    r.im = in_w'(im);
    return r;
  endfunction

  // natural sample order onto the lanes
  function automatic quad_in_t quad(input cplx_in_t x0, input cplx_in_t x1,
                                    input cplx_in_t x2, input cplx_in_t x3);
    quad_in_t q;
    q.in0_up   = x0;
    q.in0_down = x2;
    q.in1_up   = x1;
    q.in1_down = x3;
    return q;
  endfunction

  // called on a falling edge and returns on the next one
  task automatic drive_set(input quad_in_t v, input logic [2:0] tid);
    din     = v;
    test_id = tid;
    @(negedge clk);
    since_rst++;
  endtask

  task automatic drive_random(input int n, input logic [2:0] tid);
    quad_in_t v;
    repeat (n) begin
      v.in0_up.re   = in_w'($random(seed));
      v.in0_up.im   = in_w'($random(seed));
      v.in0_down.re = in_w'($random(seed));
      v.in0_down.im = in_w'($random(seed));
      v.in1_up.re   = in_w'($random(seed));
      v.in1_up.im   = in_w'($random(seed));
      v.in1_down.re = in_w'($random(seed));
      v.in1_down.im = in_w'($random(seed));
      drive_set(v, tid);
    end
  endtask

  task automatic pad_zero(input int upto, input logic [2:0] tid);
    while (since_rst < upto) begin
      drive_set('0, tid);
    end
  endtask

  // dc set and then an impulse on each sample
  task automatic drive_known(input logic [2:0] tid);
    cplx_in_t dc;
    cplx_in_t imp;
    cplx_in_t z;
    dc  = cplx(100, -60);
    imp = cplx(250, -170);
    z   = cplx(0, 0);
    drive_set(quad(dc, dc, dc, dc), tid);
    drive_set(quad(imp, z, z, z), tid);
    drive_set(quad(z, imp, z, z), tid);
    drive_set(quad(z, z, imp, z), tid);
    drive_set(quad(z, z, z, imp), tid);
  endtask

  // full-scale differences push the odd bins past Q3.12
  task automatic drive_saturation(input logic [2:0] tid);
    cplx_in_t p;
    cplx_in_t n;
    cplx_in_t p2;
    cplx_in_t n2;
    p  = cplx(511, 511);
    n  = cplx(-512, -512);
    p2 = cplx(511, -512);
    n2 = cplx(-512, 511);
    // X1 real high and then low
    drive_set(quad(p, p, n, n), tid);
    drive_set(quad(n, n, p, p), tid);
    // X3 real high and then low
    drive_set(quad(p, n, n, p), tid);
    drive_set(quad(n, p, p, n), tid);
    // X1 imaginary low and then high
    drive_set(quad(p2, p2, n2, n2), tid);
    drive_set(quad(n2, n2, p2, p2), tid);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    rst     = 1'b1;
    din     = '0;
    test_id = 3'd0;
    // three rising edges in reset
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst       = 1'b0;
    since_rst = 0;
    // known sets in both halves of the first window
    drive_known(3'd1);
    pad_zero(twd_period / 2, 3'd1);
    drive_known(3'd1);
    pad_zero(n_known, 3'd1);
    drive_random(n_random, 3'd2);
    drive_saturation(3'd3);
    // reset lands in the second half of a window
    drive_random(n_pre_rst, 3'd4);
    rst = 1'b1;
    drive_random(n_rst_mid, 3'd4);
    rst       = 1'b0;
    since_rst = 0;
    drive_random(n_post_rst, 3'd4);
    // flush the last sets out of the pipeline
    pad_zero(n_post_rst + n_flush, 3'd4);
    if (sets_checked == 0) begin
      $display("no output set was compared during the run");
    end
    $display("errors: %0d value, %0d enable, %0d output sets checked",
             value_errs, enable_errs, sets_checked);
    if (value_errs == 0 && enable_errs == 0 && sets_checked > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((num_vectors + 10) * clk_period);
    $display("timeout: the run did not finish within %0d clock cycles", num_vectors + 10);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: sim.f
hw/fft_pkg.sv
hw/fft_sequencer.sv
hw/stage1_butterfly.sv
hw/stage2_butterfly.sv
hw/csd_rotator.sv
hw/fft_out_stage.sv
hw/fft4_front.sv
testbench/fft4_checker.sv
testbench/tb_fft4_front.sv
